// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // bus and instruction widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // first fetch address out of reset
    localparam logic [addr_w-1:0] reset_pc = 32'h0000_0000;

    // instruction memory geometry
    // word index taken from address bits 6:2, upper bits ignored
    localparam int rom_words   = 32;
    localparam int rom_index_w = 5;

    // cycles from accepted address to data_ok1
    localparam int rom_latency = 3;

    // primary opcode of J
    localparam logic [5:0] op_jump = 6'd2;

    // program image for inst_rom
    localparam rom_file = "inst_rom.hex";

endpackage

// ==== design/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              advance,
    input  logic              jump_taken,
    input  logic [addr_w-1:0] jump_target,
    output logic [addr_w-1:0] pc,
    output logic              fetch_en
);

    logic [addr_w-1:0] seq_pc;

    // aligned pc fetches a pair, otherwise a single word
    assign seq_pc = pc[2] ? pc + addr_w'(4) : pc + addr_w'(8);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= reset_pc;
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;  // fetch starts one cycle after reset
            if (advance) begin
                pc <= jump_taken ? jump_target : seq_pc;
            end
        end
    end

    // jump targets come back from predecode, so check the whole loop
    a_pc_word_aligned: assert property (
        @(posedge clk) disable iff (reset)
        advance |=> pc[1:0] == 2'b00
    );

endmodule

// ==== design/inst_bridge.sv ====
`timescale 1ns/1ps

module inst_bridge import fetch_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // core side
    input  logic              inst_sram_en,
    input  logic [addr_w-1:0] inst_sram_addr,
    input  logic              longest_stall,
    output logic [data_w-1:0] inst_sram_rdata1,
    output logic [data_w-1:0] inst_sram_rdata2,
    output logic              inst_sram_data_ok1,
    output logic              inst_sram_data_ok2,
    output logic              i_stall,
    // sram-like bus
    output logic              inst_req,
    output logic [addr_w-1:0] inst_addr,
    input  logic              inst_addr_ok,
    input  logic              inst_data_ok1,
    input  logic              inst_data_ok2,
    input  logic [data_w-1:0] inst_rdata1,
    input  logic [data_w-1:0] inst_rdata2
);

    logic addr_rcv;   // address taken, waiting for data
    logic do_finish;  // data back, held until the core moves on

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_rcv <= 1'b0;
        end else if (inst_data_ok1) begin
            addr_rcv <= 1'b0;  // data_ok wins over a coincident addr_ok
        end else if (inst_req && inst_addr_ok) begin
            addr_rcv <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            do_finish          <= 1'b0;
            inst_sram_data_ok1 <= 1'b0;
            inst_sram_data_ok2 <= 1'b0;
        end else begin
            if (inst_data_ok1) begin
                do_finish <= 1'b1;
            end else if (!longest_stall) begin
                do_finish <= 1'b0;
            end
            inst_sram_data_ok1 <= inst_data_ok1;
            inst_sram_data_ok2 <= inst_data_ok2;
        end
    end

    // returned words stay put until the next transaction
    always_ff @(posedge clk) begin
        if (inst_data_ok1) begin
            inst_sram_rdata1 <= inst_rdata1;
        end
        if (inst_data_ok2) begin
            inst_sram_rdata2 <= inst_rdata2;
        end
    end

    // no new request while the back end is stalled
    assign inst_req  = inst_sram_en & ~addr_rcv & ~do_finish & ~longest_stall;
    assign inst_addr = inst_sram_addr;
    assign i_stall   = inst_sram_en & ~do_finish;

    // one transaction in flight at a time
    a_single_outstanding: assert property (
        @(posedge clk) disable iff (reset)
        (inst_req && inst_addr_ok) |=> !inst_req until_with inst_data_ok1
    );

endmodule

// ==== design/inst_rom.sv ====
`timescale 1ns/1ps

module inst_rom import fetch_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              inst_req,
    input  logic [addr_w-1:0] inst_addr,
    output logic              inst_addr_ok,
    output logic              inst_data_ok1,
    output logic              inst_data_ok2,
    output logic [data_w-1:0] inst_rdata1,
    output logic [data_w-1:0] inst_rdata2
);

    logic [data_w-1:0] mem [rom_words];

    logic                           rom_ready;  // low for the first cycle out of reset
    logic                           busy;
    logic [$clog2(rom_latency)-1:0] lat_cnt;
    logic                           pair_q;     // second word returned
    logic [rom_index_w-1:0]         idx;
    logic [rom_index_w-1:0]         idx_next;
    logic                           accept;

    initial begin
        $readmemh(rom_file, mem);
    end

    assign idx      = inst_addr[rom_index_w+1:2];
    assign idx_next = idx + 1'b1;  // wraps at the end of the image
    assign accept   = inst_req & inst_addr_ok;

    assign inst_addr_ok  = rom_ready & ~busy;
    assign inst_data_ok1 = busy & (lat_cnt == '0);
    assign inst_data_ok2 = inst_data_ok1 & pair_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rom_ready <= 1'b0;
            busy      <= 1'b0;
            lat_cnt   <= '0;
        end else begin
            rom_ready <= 1'b1;
            if (accept) begin
                busy    <= 1'b1;
                lat_cnt <= $bits(lat_cnt)'(rom_latency - 1);
            end else if (busy) begin
                if (lat_cnt == '0) begin
                    busy <= 1'b0;  // response goes out this cycle
                end else begin
                    lat_cnt <= lat_cnt - 1'b1;
                end
            end
        end
    end

    // read on acceptance, hold until the response
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_rdata1 <= mem[idx];
            inst_rdata2 <= mem[idx_next];
            pair_q      <= ~inst_addr[2];
        end
    end

    // every response traces back to an accepted address
    a_no_idle_response: assert property (
        @(posedge clk) disable iff (reset)
        inst_data_ok1 |-> $past(inst_req && inst_addr_ok, rom_latency)
    );

endmodule

// ==== design/inst_predecode.sv ====
`timescale 1ns/1ps

module inst_predecode import fetch_pkg::*; (
    input  logic [addr_w-1:0] pc,
    input  logic [data_w-1:0] inst0,
    input  logic [data_w-1:0] inst1,
    input  logic              inst0_valid,
    input  logic              inst1_valid,
    output logic              jump_taken,
    output logic [addr_w-1:0] jump_target,
    output logic              slot1_keep
);

    logic              jump0;
    logic              jump1;
    logic [addr_w-1:0] pc_slot1;
    logic [addr_w-1:0] seg0;  // pc + 4 of slot 0
    logic [addr_w-1:0] seg1;  // pc + 4 of slot 1

    assign pc_slot1 = pc + addr_w'(4);
    assign seg0     = pc_slot1;
    assign seg1     = pc_slot1 + addr_w'(4);

    assign jump0 = inst0_valid && (inst0[31:26] == op_jump);
    assign jump1 = inst1_valid && (inst1[31:26] == op_jump);

    always_comb begin
        jump_taken  = 1'b0;
        jump_target = seg0;
        if (jump0) begin
            jump_taken  = 1'b1;
            jump_target = {seg0[addr_w-1:28], inst0[25:0], 2'b00};
        end else if (jump1) begin
            jump_taken  = 1'b1;
            jump_target = {seg1[addr_w-1:28], inst1[25:0], 2'b00};
        end
    end

    // slot 1 falls behind a jump in slot 0
    assign slot1_keep = ~jump0;

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              longest_stall,
    output logic              fetch_valid,
    output logic [addr_w-1:0] fetch_pc,
    output logic [data_w-1:0] fetch_inst0,
    output logic [data_w-1:0] fetch_inst1,
    output logic              fetch_inst1_valid
);

    logic [addr_w-1:0] pc;
    logic              fetch_en;
    logic              advance;
    logic              fetch_done;
    logic              jump_taken;
    logic [addr_w-1:0] jump_target;
    logic              slot1_keep;

    logic              inst_sram_data_ok1;
    logic              inst_sram_data_ok2;
    logic              i_stall;

    logic              inst_req;
    logic [addr_w-1:0] inst_addr;
    logic              inst_addr_ok;
    logic              inst_data_ok1;
    logic              inst_data_ok2;
    logic [data_w-1:0] inst_rdata1;
    logic [data_w-1:0] inst_rdata2;

    // bundle held in the bridge, core not yet moved on
    assign fetch_done = fetch_en & ~i_stall;
    assign advance    = fetch_done & ~longest_stall;

    pc_gen u_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .pc          (pc),
        .fetch_en    (fetch_en)
    );

    inst_bridge u_inst_bridge (
        .clk                (clk),
        .reset              (reset),
        .inst_sram_en       (fetch_en),
        .inst_sram_addr     (pc),
        .longest_stall      (longest_stall),
        .inst_sram_rdata1   (fetch_inst0),
        .inst_sram_rdata2   (fetch_inst1),
        .inst_sram_data_ok1 (inst_sram_data_ok1),
        .inst_sram_data_ok2 (inst_sram_data_ok2),
        .i_stall            (i_stall),
        .inst_req           (inst_req),
        .inst_addr          (inst_addr),
        .inst_addr_ok       (inst_addr_ok),
        .inst_data_ok1      (inst_data_ok1),
        .inst_data_ok2      (inst_data_ok2),
        .inst_rdata1        (inst_rdata1),
        .inst_rdata2        (inst_rdata2)
    );

    inst_rom u_inst_rom (
        .clk           (clk),
        .reset         (reset),
        .inst_req      (inst_req),
        .inst_addr     (inst_addr),
        .inst_addr_ok  (inst_addr_ok),
        .inst_data_ok1 (inst_data_ok1),
        .inst_data_ok2 (inst_data_ok2),
        .inst_rdata1   (inst_rdata1),
        .inst_rdata2   (inst_rdata2)
    );

    inst_predecode u_inst_predecode (
        .pc          (pc),
        .inst0       (fetch_inst0),
        .inst1       (fetch_inst1),
        .inst0_valid (fetch_done),
        .inst1_valid (fetch_done & ~pc[2]),  // pair only from an aligned pc
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .slot1_keep  (slot1_keep)
    );

    assign fetch_valid       = inst_sram_data_ok1;
    assign fetch_pc          = pc;
    assign fetch_inst1_valid = inst_sram_data_ok2 & slot1_keep;

endmodule

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam int reset_cycles   = 16;
    localparam int fetch_spacing  = 5;
    localparam int total_fetches  = 44;
    localparam int timeout_cycles = reset_cycles + fetch_spacing * total_fetches + 200;

    logic              clk;
    logic              reset;
    logic              longest_stall;
    logic              fetch_valid;
    logic [addr_w-1:0] fetch_pc;
    logic [data_w-1:0] fetch_inst0;
    logic [data_w-1:0] fetch_inst1;
    logic              fetch_inst1_valid;

    logic [data_w-1:0] model_mem [rom_words];
    logic [addr_w-1:0] model_pc;  // address of the next expected bundle
    logic [addr_w-1:0] req_addr;
    int                req_cycle;
    int                cycle;
    int                last_bundle;
    int                prev_bundle;
    int                err_count;
    int                failed_tests;
    int                bundle_count;
    int                seed;

    fetch_top u_dut (
        .clk               (clk),
        .reset             (reset),
        .longest_stall     (longest_stall),
        .fetch_valid       (fetch_valid),
        .fetch_pc          (fetch_pc),
        .fetch_inst0       (fetch_inst0),
        .fetch_inst1       (fetch_inst1),
        .fetch_inst1_valid (fetch_inst1_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("run timed out after %0d cycles", cycle);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // last address accepted on the rom bus
    always @(negedge clk) begin
        if (u_dut.inst_req && u_dut.inst_addr_ok) begin
            req_addr  <= u_dut.inst_addr;
            req_cycle <= cycle;
        end
    end

    function automatic logic is_jump(input logic [data_w-1:0] word);
        return word[31:26] == op_jump;
    endfunction

    // top nibble comes from slot address + 4
    function automatic logic [addr_w-1:0] jump_dest(input logic [addr_w-1:0] slot_addr,
                                                    input logic [data_w-1:0] word);
        logic [addr_w-1:0] next_addr;
        next_addr = slot_addr + 4;
        return {next_addr[addr_w-1:28], word[25:0], 2'b00};
    endfunction

    task automatic check_addr(input string name, input logic [addr_w-1:0] expected,
                              input logic [addr_w-1:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_inst(input string name, input logic [data_w-1:0] expected,
                              input logic [data_w-1:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] %s: expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            err_count++;
            $display("[FAIL] %s: expected %0d cycles, actual %0d", name, expected, actual);
        end
    endtask

    // wait for the next bundle, compare it with the image and step the model pc
    task automatic expect_bundle(input string name);
        logic [rom_index_w-1:0] idx;
        logic [data_w-1:0]      word0;
        logic [data_w-1:0]      word1;
        logic                   slot1_live;
        @(negedge clk);
        while (!fetch_valid) begin
            @(negedge clk);
        end
        prev_bundle = last_bundle;
        last_bundle = cycle;
        idx         = model_pc[rom_index_w+1:2];
        word0       = model_mem[idx];
        word1       = model_mem[idx + 1'b1];  // wraps past the last word
        slot1_live  = !model_pc[2] && !is_jump(word0);
        check_addr(name, model_pc, fetch_pc);
        check_addr(name, model_pc, req_addr);
        check_cycles(name, 4, last_bundle - req_cycle);
        check_inst(name, word0, fetch_inst0);
        check_bit(name, slot1_live, fetch_inst1_valid);
        if (slot1_live) begin
            check_inst(name, word1, fetch_inst1);
        end
        if (is_jump(word0)) begin
            model_pc = jump_dest(model_pc, word0);
        end else if (slot1_live && is_jump(word1)) begin
            model_pc = jump_dest(model_pc + 4, word1);
        end else begin
            model_pc = model_pc + (model_pc[2] ? 4 : 8);
        end
        bundle_count++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %-10s ok", name);
        end else begin
            failed_tests++;
            $display("test %-10s failed with %0d error(s)", name, err_count - errs_before);
        end
    endtask

    task automatic reset_sequence();
        int errs_before;
        errs_before = err_count;
        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_bit("reset", 1'b0, fetch_valid);
            check_bit("reset", 1'b0, fetch_inst1_valid);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);  // first cycle out of reset
        check_bit("reset", 1'b0, fetch_valid);
        check_bit("reset", 1'b0, fetch_inst1_valid);
        check_addr("reset", reset_pc, fetch_pc);
        expect_bundle("reset");
        report_test("reset", errs_before);
    endtask

    task automatic sequential_pairs();
        int errs_before;
        errs_before = err_count;
        repeat (2) begin
            expect_bundle("seq");
            check_cycles("seq", fetch_spacing, last_bundle - prev_bundle);
        end
        report_test("seq", errs_before);
    endtask

    task automatic slot0_jump();
        int errs_before;
        errs_before = err_count;
        if (!is_jump(model_mem[model_pc[rom_index_w+1:2]])) begin
            err_count++;
            $display("image holds no J in slot 0 at pc 0x%08h", model_pc);
        end
        expect_bundle("jump_slot0");
        check_bit("jump_slot0", 1'b0, fetch_inst1_valid);
        @(negedge clk);
        check_addr("jump_slot0", model_pc, fetch_pc);
        report_test("jump_slot0", errs_before);
    endtask

    task automatic slot1_jump();
        int errs_before;
        errs_before = err_count;
        expect_bundle("jump_slot1");
        check_bit("jump_slot1", 1'b1, fetch_inst1_valid);
        @(negedge clk);
        check_addr("jump_slot1", model_pc, fetch_pc);
        expect_bundle("jump_slot1");  // lone word at the unaligned target
        check_bit("jump_slot1", 1'b0, fetch_inst1_valid);
        check_bit("jump_slot1", 1'b1, fetch_pc[2]);
        @(negedge clk);
        check_addr("jump_slot1", model_pc, fetch_pc);
        report_test("jump_slot1", errs_before);
    endtask

    task automatic stall_windows();
        int                errs_before;
        int                hold;
        logic [addr_w-1:0] held_pc;
        logic [data_w-1:0] held_inst0;
        logic [data_w-1:0] held_inst1;
        errs_before = err_count;
        repeat (4) begin
            hold = 1 + ($unsigned($random(seed)) % 8);
            @(posedge clk);
            @(posedge clk);
            longest_stall <= 1'b1;  // request already out, data lands inside the window
            expect_bundle("stall");
            held_pc    = fetch_pc;
            held_inst0 = fetch_inst0;
            held_inst1 = fetch_inst1;
            repeat (hold) begin
                @(negedge clk);
                check_bit("stall", 1'b0, fetch_valid);
                check_bit("stall", 1'b0, u_dut.inst_req);
                check_addr("stall", held_pc, fetch_pc);
                check_inst("stall", held_inst0, fetch_inst0);
                check_inst("stall", held_inst1, fetch_inst1);
            end
            @(posedge clk);
            longest_stall <= 1'b0;
            expect_bundle("stall");
        end
        report_test("stall", errs_before);
    endtask

    task automatic full_image_run();
        int errs_before;
        errs_before = err_count;
        repeat (30) begin
            expect_bundle("image");  // runs past 0x80 and loops back
        end
        report_test("image", errs_before);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        longest_stall = 1'b0;
        cycle         = 0;
        req_cycle     = 0;
        last_bundle   = 0;
        prev_bundle   = 0;
        err_count     = 0;
        failed_tests  = 0;
        bundle_count  = 0;
        seed          = 65;
        model_pc      = reset_pc;
        $readmemh("design/inst_rom.hex", model_mem);
        $readmemh("design/inst_rom.hex", u_dut.u_inst_rom.mem);  // image path from project root
        reset_sequence();
        sequential_pairs();
        slot0_jump();
        slot1_jump();
        stall_windows();
        full_image_run();
        $display("tests failed %0d of 6, errors %0d, bundles %0d, cycles %0d",
                 failed_tests, err_count, bundle_count, cycle);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== design/inst_rom.hex ====
// one 32-bit instruction word per line, word index 0 to 31
24000000
24000001
24000002
24000003
24000004
24000005
0800000a // j 0x28
24000007
24000008
24000009
2400000a
0800000d // j 0x34, unaligned target
2400000c
2400000d
2400000e
2400000f
24000010
24000011
24000012
24000013
24000014
24000015
24000016
24000017
24000018
24000019
2400001a
2400001b
2400001c
2400001d
2400001e
2400001f

// ==== tb.f ====
design/fetch_pkg.sv
design/pc_gen.sv
design/inst_bridge.sv
design/inst_rom.sv
design/inst_predecode.sv
design/fetch_top.sv
dv/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - design/fetch_pkg.sv
  - design/pc_gen.sv
  - design/inst_bridge.sv
  - design/inst_rom.sv
  - design/inst_predecode.sv
  - design/fetch_top.sv
  - target: test
    files:
      - dv/fetch_tb.sv
